//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bypass testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module bypass_tb -f sim.f > build.log 2>&1 \
    || { cat build.log; echo "run_sim: build failed"; exit 1; }

./obj_dir/Vbypass_tb > sim.log 2>&1
cat sim.log

grep -qx "Simulation finished: PASS" sim.log \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed"; exit 1; }

//--- sim.f
src/fwd_pkg.sv
src/op_queue.sv
src/reg_file.sv
src/operand_bypass.sv
src/exec_pipe.sv
src/issue_fsm.sv
src/drain_timer.sv
src/bypass_top.sv
tb/tb_clock.sv
tb/bypass_assertions.sv
tb/bypass_tb.sv

//--- src/bypass_top.sv
`timescale 1ns/1ps
`default_nettype none

module bypass_top #(
    parameter int queue_depth = 8,
    parameter int pipe_depth  = 3
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [fwd_pkg::apb_addr_width-1:0]  paddr,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire  [fwd_pkg::apb_data_width-1:0]  pwdata,
    output logic [fwd_pkg::apb_data_width-1:0]  prdata,
    output logic                                pready,
    output logic                                pslverr
);
    import fwd_pkg::*;

    logic                      push;
    logic [op_word_width-1:0]  push_data;
    logic [op_word_width-1:0]  head_data;
    logic                      full;
    logic                      empty;
    logic                      pop;
    logic                      start;
    logic                      drained;
    logic                      retire;
    logic [31:0]               retired_count;
    logic [reg_addr_width-1:0] host_raddr;
    logic [xlen-1:0]           host_rdata;

    // read stage fields, straight off the queue head
    alu_op_e                   issue_op;
    logic [reg_addr_width-1:0] issue_rd;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [imm_width-1:0]      issue_imm;
    logic [xlen-1:0]           rf_rdata1;
    logic [xlen-1:0]           rf_rdata2;
    logic [xlen-1:0]           op_a;
    logic [xlen-1:0]           op_b;

    logic                      ex_valid;
    logic [reg_addr_width-1:0] ex_rd;
    logic [xlen-1:0]           ex_result;
    logic                      mem_valid;
    logic [reg_addr_width-1:0] mem_rd;
    logic [xlen-1:0]           mem_result;
    logic                      wb_en;
    logic [reg_addr_width-1:0] wb_addr;
    logic [xlen-1:0]           wb_data;

    assign issue_op  = alu_op_e'(head_data[opcode_lsb +: opcode_width]);
    assign issue_rd  = head_data[rd_lsb +: reg_addr_width];
    assign rs1       = head_data[rs1_lsb +: reg_addr_width];
    assign rs2       = head_data[rs2_lsb +: reg_addr_width];
    assign issue_imm = head_data[imm_lsb +: imm_width];

    issue_fsm #(.queue_depth(queue_depth)) issue_fsm_inst (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
        .pready, .pslverr, .push, .push_data, .full, .empty, .pop, .start,
        .drained, .host_raddr, .host_rdata, .retired_count
    );

    op_queue #(.queue_depth(queue_depth)) op_queue_inst (
        .clk, .rst_n, .push, .push_data, .pop, .head_data, .full, .empty
    );

    reg_file reg_file_inst (
        .clk, .rst_n, .raddr1(rs1), .raddr2(rs2), .host_raddr,
        .rdata1(rf_rdata1), .rdata2(rf_rdata2), .host_rdata,
        .wb_en, .wb_addr, .wb_data
    );

    operand_bypass operand_bypass_inst (
        .rs1, .rs2, .ex_valid, .ex_rd, .ex_result, .mem_valid, .mem_rd,
        .mem_result, .rf_rdata1, .rf_rdata2, .op_a, .op_b
    );

    exec_pipe exec_pipe_inst (
        .clk, .rst_n, .issue_valid(pop), .issue_op, .issue_rd, .issue_imm,
        .op_a, .op_b, .ex_valid, .ex_rd, .ex_result, .mem_valid, .mem_rd,
        .mem_result, .wb_en, .wb_addr, .wb_data, .retire
    );

    drain_timer #(.pipe_depth(pipe_depth)) drain_timer_inst (
        .clk, .rst_n, .start, .retire, .drained, .retired_count
    );

endmodule

`default_nettype wire

//--- src/drain_timer.sv
`timescale 1ns/1ps
`default_nettype none

module drain_timer #(
    parameter int pipe_depth = 3
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    input  wire         retire,
    output logic        drained,
    output logic [31:0] retired_count
);
    localparam int cnt_width = $clog2(pipe_depth + 1);

    logic [cnt_width-1:0] count;
    logic                 active;

    // start comes one cycle after the last pop and drained is the final cycle,
    // hence the load of pipe_depth - 2
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            count  <= '0;
        end else if (start) begin
            active <= 1'b1;
            count  <= cnt_width'(pipe_depth - 2);
        end else if (drained) begin
            active <= 1'b0;
        end else if (active) begin
            count <= count - 1'b1;
        end
    end

    assign drained = active && (count == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired_count <= '0;
        end else if (retire) begin
            retired_count <= retired_count + 32'd1;
        end
    end

endmodule

`default_nettype wire

//--- src/exec_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module exec_pipe (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 issue_valid,
    input  wire  fwd_pkg::alu_op_e              issue_op,
    input  wire  [fwd_pkg::reg_addr_width-1:0]  issue_rd,
    input  wire  [fwd_pkg::imm_width-1:0]       issue_imm,
    input  wire  [fwd_pkg::xlen-1:0]            op_a,
    input  wire  [fwd_pkg::xlen-1:0]            op_b,
    output logic                                ex_valid,
    output logic [fwd_pkg::reg_addr_width-1:0]  ex_rd,
    output logic [fwd_pkg::xlen-1:0]            ex_result,
    output logic                                mem_valid,
    output logic [fwd_pkg::reg_addr_width-1:0]  mem_rd,
    output logic [fwd_pkg::xlen-1:0]            mem_result,
    output logic                                wb_en,
    output logic [fwd_pkg::reg_addr_width-1:0]  wb_addr,
    output logic [fwd_pkg::xlen-1:0]            wb_data,
    output logic                                retire
);
    import fwd_pkg::*;

    localparam int shamt_width = $clog2(xlen);

    alu_op_e                ex_op;
    logic [xlen-1:0]        ex_a;
    logic [xlen-1:0]        ex_b;
    logic [xlen-1:0]        ex_imm;
    logic [shamt_width-1:0] shamt;
    logic                   writes;

    // unknown opcodes travel with rd = 0, so they never forward or write back
    assign writes = issue_op inside {op_add, op_sub, op_and, op_or, op_xor,
                                     op_sll, op_srl, op_addi, op_li};

    //////////////////////////////
    // execute stage
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op  <= issue_op;
        ex_rd  <= writes ? issue_rd : '0;
        ex_a   <= op_a;
        ex_b   <= op_b;
        ex_imm <= {{(xlen - imm_width){issue_imm[imm_width-1]}}, issue_imm};
    end

    assign shamt = ex_b[shamt_width-1:0];

    always_comb begin
        case (ex_op)
            op_add:  ex_result = ex_a + ex_b;
            op_sub:  ex_result = ex_a - ex_b;
            op_and:  ex_result = ex_a & ex_b;
            op_or:   ex_result = ex_a | ex_b;
            op_xor:  ex_result = ex_a ^ ex_b;
            op_sll:  ex_result = ex_a << shamt;
            op_srl:  ex_result = ex_a >> shamt;   // logical
            op_addi: ex_result = ex_a + ex_imm;
            op_li:   ex_result = ex_imm;
            default: ex_result = '0;
        endcase
    end

    //////////////////////////////
    // memory stage, pass-through register only
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd     <= ex_rd;
        mem_result <= ex_result;
    end

    assign wb_en   = mem_valid && (mem_rd != '0);
    assign wb_addr = mem_rd;
    assign wb_data = mem_result;
    assign retire  = mem_valid;   // one pulse per op, writing or not

endmodule

`default_nettype wire

//--- src/fwd_pkg.sv
`default_nettype none

package fwd_pkg;

    parameter int xlen           = 64;
    parameter int reg_addr_width = 5;
    parameter int op_word_width  = 32;
    parameter int apb_addr_width = 12;
    parameter int apb_data_width = 32;

    // op word layout
    parameter int opcode_lsb   = 0;
    parameter int opcode_width = 4;
    parameter int rd_lsb       = 4;
    parameter int rs1_lsb      = 9;
    parameter int rs2_lsb      = 14;
    parameter int imm_lsb      = 19;
    parameter int imm_width    = 13;  // signed

    typedef enum logic [opcode_width-1:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_addi = 4'd7,
        op_li   = 4'd8
    } alu_op_e;

    //////////////////////////////
    // apb map
    //////////////////////////////
    parameter logic [apb_addr_width-1:0] addr_op      = 12'h000;
    parameter logic [apb_addr_width-1:0] addr_ctrl    = 12'h004;
    parameter logic [apb_addr_width-1:0] addr_status  = 12'h008;
    parameter logic [apb_addr_width-1:0] addr_retired = 12'h00c;
    parameter logic [apb_addr_width-1:0] addr_reg_lo  = 12'h100;  // + 4*n
    parameter logic [apb_addr_width-1:0] addr_reg_hi  = 12'h180;  // + 4*n

    typedef enum logic [1:0] {
        idle,
        run,
        drain
    } fsm_state_e;

endpackage

`default_nettype wire

//--- src/issue_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module issue_fsm #(
    parameter int queue_depth = 8
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [fwd_pkg::apb_addr_width-1:0]  paddr,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire  [fwd_pkg::apb_data_width-1:0]  pwdata,
    output logic [fwd_pkg::apb_data_width-1:0]  prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                push,
    output logic [fwd_pkg::op_word_width-1:0]   push_data,
    input  wire                                 full,
    input  wire                                 empty,
    output logic                                pop,
    output logic                                start,
    input  wire                                 drained,
    output logic [fwd_pkg::reg_addr_width-1:0]  host_raddr,
    input  wire  [fwd_pkg::xlen-1:0]            host_rdata,
    input  wire  [31:0]                         retired_count
);
    import fwd_pkg::*;

    fsm_state_e state;
    fsm_state_e state_next;
    logic       access;
    logic       busy;
    logic       wr_op;
    logic       wr_ctrl;
    logic       rd_status;
    logic       rd_retired;
    logic       rd_reg;
    logic       reg_hi;
    logic       run_req;
    logic       err;

    //////////////////////////////
    // apb decode
    //////////////////////////////
    assign access     = psel && penable;
    assign busy       = (state != idle);
    assign wr_op      = access && pwrite && (paddr == addr_op);
    assign wr_ctrl    = access && pwrite && (paddr == addr_ctrl);
    assign rd_status  = access && !pwrite && (paddr == addr_status);
    assign rd_retired = access && !pwrite && (paddr == addr_retired);
    assign rd_reg     = access && !pwrite && ((paddr & 12'hf00) == addr_reg_lo);
    assign reg_hi     = ((paddr & 12'hf80) == addr_reg_hi);
    assign host_raddr = paddr[2 +: reg_addr_width];

    assign push      = wr_op && !full && !busy;
    assign push_data = pwdata[op_word_width-1:0];
    assign run_req   = wr_ctrl && pwdata[0] && !busy;

    // register reads wait for the run to finish
    assign pready  = access && !(rd_reg && busy);
    assign pslverr = pready && err;

    always_comb begin
        err = 1'b0;
        if (wr_op) begin
            err = full || busy;
        end else if (wr_ctrl) begin
            err = pwdata[0] && busy;
        end else if (!(rd_status || rd_retired || rd_reg)) begin
            err = 1'b1;   // unmapped
        end
    end

    always_comb begin
        prdata = '0;
        if (rd_status) begin
            prdata = {16'h0, 8'(queue_depth), 5'h0, full, empty, busy};
        end else if (rd_retired) begin
            prdata = retired_count;
        end else if (rd_reg) begin
            prdata = reg_hi ? host_rdata[xlen-1:32] : host_rdata[31:0];
        end
    end

    //////////////////////////////
    // run control
    //////////////////////////////
    always_comb begin
        state_next = state;
        pop        = 1'b0;
        start      = 1'b0;
        case (state)
            idle: begin
                if (run_req) begin
                    state_next = run;
                end
            end
            run: begin
                if (empty) begin
                    start      = 1'b1;  // kick the drain timer
                    state_next = drain;
                end else begin
                    pop = 1'b1;
                end
            end
            drain: begin
                if (drained) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

//--- src/op_queue.sv
`timescale 1ns/1ps
`default_nettype none

module op_queue #(
    parameter int queue_depth = 8
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                push,
    input  wire  [fwd_pkg::op_word_width-1:0]  push_data,
    input  wire                                pop,
    output logic [fwd_pkg::op_word_width-1:0]  head_data,
    output logic                               full,
    output logic                               empty
);
    import fwd_pkg::*;

    localparam int ptr_width = $clog2(queue_depth);

    logic [op_word_width-1:0] mem [queue_depth];
    logic [ptr_width-1:0]     wr_ptr;
    logic [ptr_width-1:0]     rd_ptr;
    logic [ptr_width:0]       count;
    logic                     do_push;
    logic                     do_pop;

    assign full    = (count == (ptr_width + 1)'(queue_depth));
    assign empty   = (count == '0);
    assign do_push = push && !full;   // push on full is dropped
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push != do_pop) begin
                count <= do_push ? count + 1'b1 : count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head_data = mem[rd_ptr];

endmodule

`default_nettype wire

//--- src/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass (
    input  wire  [fwd_pkg::reg_addr_width-1:0]  rs1,
    input  wire  [fwd_pkg::reg_addr_width-1:0]  rs2,
    input  wire                                 ex_valid,
    input  wire  [fwd_pkg::reg_addr_width-1:0]  ex_rd,
    input  wire  [fwd_pkg::xlen-1:0]            ex_result,
    input  wire                                 mem_valid,
    input  wire  [fwd_pkg::reg_addr_width-1:0]  mem_rd,
    input  wire  [fwd_pkg::xlen-1:0]            mem_result,
    input  wire  [fwd_pkg::xlen-1:0]            rf_rdata1,
    input  wire  [fwd_pkg::xlen-1:0]            rf_rdata2,
    output logic [fwd_pkg::xlen-1:0]            op_a,
    output logic [fwd_pkg::xlen-1:0]            op_b
);
    import fwd_pkg::*;

    logic ex_hit_a;
    logic ex_hit_b;
    logic mem_hit_a;
    logic mem_hit_b;

    // a stage supplies src when it holds a live write to the same non-zero reg
    function automatic logic stage_match(
        input logic                      valid,
        input logic [reg_addr_width-1:0] rd,
        input logic [reg_addr_width-1:0] src
    );
        return valid && (rd == src) && (src != '0);
    endfunction

    assign ex_hit_a  = stage_match(ex_valid, ex_rd, rs1);
    assign ex_hit_b  = stage_match(ex_valid, ex_rd, rs2);
    assign mem_hit_a = stage_match(mem_valid, mem_rd, rs1);
    assign mem_hit_b = stage_match(mem_valid, mem_rd, rs2);

    //////////////////////////////
    // newest value wins: ex, then mem, then file
    //////////////////////////////
    always_comb begin
        if (ex_hit_a) begin
            op_a = ex_result;
        end else if (mem_hit_a) begin
            op_a = mem_result;
        end else begin
            op_a = rf_rdata1;
        end
    end

    always_comb begin
        if (ex_hit_b) begin
            op_b = ex_result;
        end else if (mem_hit_b) begin
            op_b = mem_result;
        end else begin
            op_b = rf_rdata2;
        end
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [fwd_pkg::reg_addr_width-1:0]  raddr1,
    input  wire  [fwd_pkg::reg_addr_width-1:0]  raddr2,
    input  wire  [fwd_pkg::reg_addr_width-1:0]  host_raddr,
    output logic [fwd_pkg::xlen-1:0]            rdata1,
    output logic [fwd_pkg::xlen-1:0]            rdata2,
    output logic [fwd_pkg::xlen-1:0]            host_rdata,
    input  wire                                 wb_en,
    input  wire  [fwd_pkg::reg_addr_width-1:0]  wb_addr,
    input  wire  [fwd_pkg::xlen-1:0]            wb_data
);
    import fwd_pkg::*;

    localparam int num_regs = 2 ** reg_addr_width;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin  // x0 stays zero
            regs[wb_addr] <= wb_data;
        end
    end

    // asynchronous reads, x0 forced to zero
    assign rdata1     = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2     = (raddr2 == '0) ? '0 : regs[raddr2];
    assign host_rdata = (host_raddr == '0) ? '0 : regs[host_raddr];

endmodule

`default_nettype wire

//--- tb/bypass_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module bypass_assertions (
    input wire                                 clk,
    input wire                                 rst_n,
    input wire                                 pready,
    input wire                                 pslverr,
    input wire                                 wb_en,
    input wire [fwd_pkg::reg_addr_width-1:0]   wb_addr,
    input wire                                 ex_valid,
    input wire [fwd_pkg::reg_addr_width-1:0]   ex_rd,
    input wire                                 mem_valid,
    input wire [fwd_pkg::reg_addr_width-1:0]   mem_rd,
    input wire [fwd_pkg::reg_addr_width-1:0]   rs1,
    input wire [fwd_pkg::xlen-1:0]             op_a,
    input wire [fwd_pkg::xlen-1:0]             ex_result
);

    int unsigned fail_count = 0;

    err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> pready)
        else begin
            $error("pslverr raised while pready is low");
            fail_count++;
        end

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> (wb_addr != '0))
        else begin
            $error("write-back aimed at x0");
            fail_count++;
        end

    // both stages hold rs1, the younger execute result must win
    ex_over_mem: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_valid && mem_valid && ex_rd == rs1 && mem_rd == rs1 && rs1 != '0)
        |-> (op_a == ex_result))
        else begin
            $error("op_a did not take the execute result");
            fail_count++;
        end

endmodule

bind bypass_top bypass_assertions bypass_assertions_inst (
    .clk(clk), .rst_n(rst_n), .pready(pready), .pslverr(pslverr),
    .wb_en(wb_en), .wb_addr(wb_addr), .ex_valid(ex_valid), .ex_rd(ex_rd),
    .mem_valid(mem_valid), .mem_rd(mem_rd), .rs1(rs1), .op_a(op_a),
    .ex_result(ex_result)
);

`default_nettype wire

//--- tb/bypass_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bypass_tb;
    import fwd_pkg::*;

    localparam int queue_depth = 8;
    localparam int pipe_depth  = 3;

    typedef enum int {k_push, k_run, k_read, k_read_err} entry_kind_e;

    logic                      clk;
    logic                      rst_n;
    logic [apb_addr_width-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_data_width-1:0] pwdata;
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;

    // stimulus table, one entry per apb access
    entry_kind_e               kind_q[$];
    logic [apb_addr_width-1:0] addr_q[$];
    logic [31:0]               data_q[$];

    // reference model
    logic [xlen-1:0] model_regs [32];
    logic [31:0]     pend_q[$];     // ops accepted but not yet run
    int unsigned     model_retired;
    logic            model_busy;

    logic [31:0] lcg_state;
    int          cycles;
    int          cycle_limit;

    tb_clock clock_inst (.clk, .rst_n);

    bypass_top #(.queue_depth(queue_depth), .pipe_depth(pipe_depth)) bypass_top_inst (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
        .pready, .pslverr
    );

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] make_op(input logic [3:0] opc, input int rd,
                                            input int rs1, input int rs2, input int imm);
        logic [31:0] w;
        w        = '0;
        w[3:0]   = opc;
        w[8:4]   = rd[4:0];
        w[13:9]  = rs1[4:0];
        w[18:14] = rs2[4:0];
        w[31:19] = imm[12:0];
        return w;
    endfunction

    function automatic void add_entry(input entry_kind_e kind, input logic [11:0] addr,
                                      input logic [31:0] data);
        kind_q.push_back(kind);
        addr_q.push_back(addr);
        data_q.push_back(data);
    endfunction

    function automatic void push_op(input logic [31:0] w);
        add_entry(k_push, addr_op, w);
    endfunction

    function automatic void read_reg(input int n);
        add_entry(k_read, addr_reg_lo + 12'(4 * n), 32'h0);
        add_entry(k_read, addr_reg_hi + 12'(4 * n), 32'h0);
    endfunction

    // sequential execution, one op at a time, no pipeline
    function automatic void model_exec(input logic [31:0] w);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm;
        logic [63:0] res;
        logic        writes;
        a      = model_regs[w[13:9]];
        b      = model_regs[w[18:14]];
        imm    = {{51{w[31]}}, w[31:19]};
        writes = 1'b1;
        res    = '0;
        case (w[3:0])
            op_add:  res = a + b;
            op_sub:  res = a - b;
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_sll:  res = a << b[5:0];
            op_srl:  res = a >> b[5:0];
            op_addi: res = a + imm;
            op_li:   res = imm;
            default: writes = 1'b0;
        endcase
        if (writes && w[8:4] != 5'd0) begin
            model_regs[w[8:4]] = res;
        end
        model_retired++;
    endfunction

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        logic [63:0] v;
        v = model_regs[addr[6:2]];
        return addr[7] ? v[63:32] : v[31:0];
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int waits);
        @(negedge clk);
        psel    = 1'b1;   // setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        @(posedge clk);
        while (!pready) begin
            waits++;
            @(posedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    //////////////////////////////
    // table
    //////////////////////////////
    function automatic void build_table();
        logic [31:0] r;
        add_entry(k_read, addr_status, 32'h2);   // idle and empty
        add_entry(k_read, addr_retired, 32'h0);
        // li seeds
        push_op(make_op(op_li, 1, 0, 0, 5));
        push_op(make_op(op_li, 2, 0, 0, -3));
        push_op(make_op(op_li, 3, 0, 0, 4095));
        push_op(make_op(op_li, 4, 0, 0, -4096));
        add_entry(k_run, addr_ctrl, 32'h1);
        for (int n = 1; n <= 4; n++) begin
            read_reg(n);
        end
        // each op uses the previous rd
        push_op(make_op(op_add, 5, 1, 2, 0));
        push_op(make_op(op_sub, 6, 5, 3, 0));
        push_op(make_op(op_xor, 7, 6, 4, 0));
        push_op(make_op(op_sll, 8, 7, 1, 0));
        push_op(make_op(op_srl, 9, 8, 1, 0));
        push_op(make_op(op_addi, 10, 9, 0, 100));
        push_op(make_op(op_and, 11, 10, 8, 0));
        push_op(make_op(op_or, 12, 11, 6, 0));
        add_entry(k_run, addr_ctrl, 32'h1);
        for (int n = 5; n <= 12; n++) begin
            read_reg(n);
        end
        // distance two, and x16 written twice in a row
        push_op(make_op(op_li, 13, 0, 0, 7));
        push_op(make_op(op_li, 14, 0, 0, 9));
        push_op(make_op(op_add, 15, 13, 14, 0));
        push_op(make_op(op_li, 16, 0, 0, 1));
        push_op(make_op(op_li, 16, 0, 0, 2));
        push_op(make_op(op_add, 17, 16, 16, 0));
        push_op(make_op(op_addi, 16, 16, 0, 5));
        push_op(make_op(op_sub, 18, 16, 17, 0));
        add_entry(k_run, addr_ctrl, 32'h1);
        for (int n = 13; n <= 18; n++) begin
            read_reg(n);
        end
        // x0 as destination and as source
        push_op(make_op(op_li, 0, 0, 0, 55));
        push_op(make_op(op_add, 19, 0, 1, 0));
        push_op(make_op(op_addi, 0, 1, 0, 1));
        push_op(make_op(op_add, 20, 0, 0, 0));
        add_entry(k_run, addr_ctrl, 32'h1);
        read_reg(0);
        read_reg(19);
        read_reg(20);
        // nine pushes, the last one hits a full queue
        for (int i = 0; i < 9; i++) begin
            push_op(make_op(op_li, 21 + i, 0, 0, 100 * i - 350));
        end
        add_entry(k_read, addr_status, 32'h4);
        add_entry(k_run, addr_ctrl, 32'h1);
        push_op(make_op(op_li, 30, 0, 0, 1));    // refused while busy
        add_entry(k_run, addr_ctrl, 32'h1);      // refused while busy
        read_reg(28);
        read_reg(29);
        add_entry(k_read, addr_retired, 32'h0);
        add_entry(k_read, addr_status, 32'h2);
        add_entry(k_read_err, 12'h010, 32'h0);
        add_entry(k_read_err, 12'h200, 32'h0);
        // twenty random ops in batches of 8, 8 and 4
        for (int i = 0; i < 20; i++) begin
            r = lcg_next();
            push_op(make_op(r[31:28] % 10, r[27:24], r[23:20], r[19:16], r[15:3]));
            if (i == 7 || i == 15 || i == 19) begin
                add_entry(k_run, addr_ctrl, 32'h1);
                read_reg(1);
            end
        end
        for (int n = 0; n < 32; n++) begin
            read_reg(n);
        end
        add_entry(k_read, addr_retired, 32'h0);
    endfunction

    task automatic apply_table();
        logic [31:0] rdata;
        logic        err;
        logic        exp_err;
        int          waits;
        for (int i = 0; i < kind_q.size(); i++) begin
            case (kind_q[i])
                k_push: begin
                    exp_err = model_busy || (pend_q.size() == queue_depth);
                    apb_access(1'b1, addr_q[i], data_q[i], rdata, err, waits);
                    check("push pslverr", err, exp_err);
                    if (!exp_err) begin
                        pend_q.push_back(data_q[i]);
                    end
                end
                k_run: begin
                    exp_err = model_busy;
                    apb_access(1'b1, addr_q[i], data_q[i], rdata, err, waits);
                    check("run pslverr", err, exp_err);
                    if (!exp_err) begin
                        while (pend_q.size() > 0) begin
                            model_exec(pend_q.pop_front());
                        end
                        model_busy = 1'b1;
                    end
                end
                k_read: begin
                    apb_access(1'b0, addr_q[i], 32'h0, rdata, err, waits);
                    check($sformatf("pslverr on read of 0x%03h", addr_q[i]), err, 1'b0);
                    if (addr_q[i][11:8] == 4'h1) begin
                        if (model_busy) begin
                            check("register read held until idle", waits > 0, 1'b1);
                            model_busy = 1'b0;
                        end
                        check($sformatf("read of 0x%03h", addr_q[i]), rdata,
                              model_read(addr_q[i]));
                    end else if (addr_q[i] == addr_retired) begin
                        check("retired count", rdata, model_retired);
                    end else begin
                        check("status bits", rdata[2:0], data_q[i][2:0]);
                    end
                end
                default: begin
                    apb_access(1'b0, addr_q[i], 32'h0, rdata, err, waits);
                    check($sformatf("pslverr on read of 0x%03h", addr_q[i]), err, 1'b1);
                end
            endcase
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the table was not done after %0d clock cycles", cycles);
            $display("Simulation finished: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    initial begin
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        cycles        = 0;
        model_busy    = 1'b0;
        model_retired = 0;
        lcg_state     = 32'h864e0852;
        for (int n = 0; n < 32; n++) begin
            model_regs[n] = '0;
        end
        build_table();
        cycle_limit = kind_q.size() * 10 + 100;
        wait (rst_n === 1'b1);
        apply_table();
        repeat (2) @(negedge clk);
        if (bypass_top_inst.bypass_assertions_inst.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period       = 100,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // released on a falling edge like every other input
    end

endmodule

`default_nettype wire
